//--- rtl/serial_slave_pkg.sv
//////////////////////////////////////////////////
// shared defaults for the serial bus slave
// the id field is $clog2(SLAVES+1) bits wide, so id 0
// is left free and ids run from 1 to SLAVES
//////////////////////////////////////////////////
package serial_slave_pkg;

    // word width of the memory and of the serial data lines
    parameter int DEF_DATA_WIDTH = 32;

    // memory depth in words
    parameter int DEF_ADDR_DEPTH = 256;

    // slaves sharing the control line
    parameter int DEF_SLAVES = 3;

    // id this slave answers to
    parameter int DEF_SLAVE_ID = 1;

    // read access delay in cycles
    parameter int DEF_DELAY = 2;

    // leading pattern of every frame on the control line
    parameter logic [2:0] START_CODE = 3'b111;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        HEADER_WAIT,
        WRITE_WORD,
        WRITE_STORE,
        READ_DELAY,
        READ_FETCH,
        READ_SEND,
        BURST_GAP
    } slave_state_e;

endpackage

//--- rtl/frame_receiver.sv
//////////////////////////////////////////////////
// frame layout, msb first
//   start(3) | id | write | burst | address
// a frame starts on the first high control bit seen
// while enable is high; enable must stay high until
// header_valid
//////////////////////////////////////////////////
`timescale 1ns/1ps

module frame_receiver #(
    parameter int SLAVES     = serial_slave_pkg::DEF_SLAVES,
    parameter int SLAVE_ID   = serial_slave_pkg::DEF_SLAVE_ID,
    parameter int ADDR_DEPTH = serial_slave_pkg::DEF_ADDR_DEPTH
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          control,
    input  logic                          enable,
    output logic                          header_valid,
    output logic                          header_match,
    output logic                          is_write,
    output logic                          is_burst,
    output logic [$clog2(ADDR_DEPTH)-1:0] start_addr
);
    localparam int ID_W      = $clog2(SLAVES + 1);
    localparam int ADDR_W    = $clog2(ADDR_DEPTH);
    localparam int FRAME_LEN = 3 + ID_W + 2 + ADDR_W;
    localparam int CNT_W     = $clog2(FRAME_LEN + 1);

    logic [FRAME_LEN-1:0] hdr;
    logic [CNT_W-1:0]     bit_cnt;
    logic                 active;
    logic                 take_bit;
    logic [2:0]           start_bits;
    logic [ID_W-1:0]      frame_id;

    // once the frame has begun every cycle carries a bit
    assign take_bit     = active ? !header_valid : (enable && control);
    assign header_valid = active && (bit_cnt == CNT_W'(FRAME_LEN));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            active  <= 1'b0;
            bit_cnt <= '0;
        end else if (header_valid) begin
            active  <= 1'b0;
            bit_cnt <= '0;
        end else if (take_bit) begin
            active  <= 1'b1;
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // header bits only, held until the next frame begins
    always_ff @(posedge clk) begin
        if (take_bit) begin
            hdr <= {hdr[FRAME_LEN-2:0], control};
        end
    end

    // field decode
    assign start_bits   = hdr[FRAME_LEN-1 -: 3];
    assign frame_id     = hdr[FRAME_LEN-4 -: ID_W];
    assign is_write     = hdr[ADDR_W+1];
    assign is_burst     = hdr[ADDR_W];
    assign start_addr   = hdr[ADDR_W-1:0];
    assign header_match = (start_bits == serial_slave_pkg::START_CODE) &&
                          (frame_id == ID_W'(SLAVE_ID));

    // the controller acts on a single decode per frame
    a_single_header: assert property (
        @(posedge clk) disable iff (!rstN) header_valid |=> !header_valid
    );

endmodule

//--- rtl/slave_controller.sv
//////////////////////////////////////////////////
// transfer sequencer; writes take bits whenever valid
// is high, reads send one word per DATA_WIDTH cycles
// with no back-pressure; a burst ends on the word in
// which last was high
//////////////////////////////////////////////////
`timescale 1ns/1ps

module slave_controller #(
    parameter int DELAY      = serial_slave_pkg::DEF_DELAY,
    parameter int ADDR_DEPTH = serial_slave_pkg::DEF_ADDR_DEPTH
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          header_valid,
    input  logic                          header_match,
    input  logic                          is_write,
    input  logic                          is_burst,
    input  logic [$clog2(ADDR_DEPTH)-1:0] start_addr,
    input  logic                          valid,
    input  logic                          last,
    input  logic                          word_done,
    output logic                          rx_enable,
    output logic                          shift_en,
    output logic                          load_word,
    output logic                          send_en,
    output logic                          mem_we,
    output logic                          mem_re,
    output logic [$clog2(ADDR_DEPTH)-1:0] mem_addr,
    output logic                          ready
);
    localparam int ADDR_W = $clog2(ADDR_DEPTH);
    localparam int DLY_W  = (DELAY > 1) ? $clog2(DELAY) : 1;

    serial_slave_pkg::slave_state_e state;

    logic [DLY_W-1:0]  dly_cnt;
    logic [ADDR_W-1:0] addr;
    logic              last_seen;
    // fetch takes two cycles, mem_re then load_word
    logic              fetch_phase;
    logic              fetching;

    assign fetching = (state == serial_slave_pkg::READ_FETCH) ||
                      (state == serial_slave_pkg::BURST_GAP);
    assign mem_addr = addr;

    always_comb begin
        rx_enable = (state == serial_slave_pkg::IDLE) ||
                    (state == serial_slave_pkg::HEADER_WAIT);
        // bits arriving during the store belong to the next word
        shift_en  = valid && ((state == serial_slave_pkg::WRITE_WORD) ||
                              (state == serial_slave_pkg::WRITE_STORE));
        send_en   = (state == serial_slave_pkg::READ_SEND);
        mem_we    = (state == serial_slave_pkg::WRITE_STORE);
        mem_re    = fetching && !fetch_phase;
        load_word = fetching && fetch_phase;
        ready     = !(fetching || (state == serial_slave_pkg::READ_DELAY));
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= serial_slave_pkg::IDLE;
            dly_cnt     <= '0;
            addr        <= '0;
            last_seen   <= 1'b0;
            fetch_phase <= 1'b0;
        end else begin
            case (state)
                // IDLE lasts one cycle after a transfer, a frame may already be arriving
                serial_slave_pkg::IDLE,
                serial_slave_pkg::HEADER_WAIT: begin
                    state <= serial_slave_pkg::HEADER_WAIT;
                    if (header_valid && !header_match) begin
                        state <= serial_slave_pkg::IDLE;
                    end else if (header_valid) begin
                        addr        <= start_addr;
                        last_seen   <= 1'b0;
                        dly_cnt     <= '0;
                        fetch_phase <= 1'b0;
                        if (is_write) begin
                            state <= serial_slave_pkg::WRITE_WORD;
                        end else if (DELAY == 0) begin
                            state <= serial_slave_pkg::READ_FETCH;
                        end else begin
                            state <= serial_slave_pkg::READ_DELAY;
                        end
                    end
                end
                serial_slave_pkg::WRITE_WORD: begin
                    if (last) begin
                        last_seen <= 1'b1;
                    end
                    if (word_done) begin
                        state <= serial_slave_pkg::WRITE_STORE;
                    end
                end
                serial_slave_pkg::WRITE_STORE: begin
                    last_seen <= 1'b0;
                    addr      <= addr + 1'b1;
                    if (!is_burst || last_seen) begin
                        state <= serial_slave_pkg::IDLE;
                    end else begin
                        state <= serial_slave_pkg::WRITE_WORD;
                    end
                end
                serial_slave_pkg::READ_DELAY: begin
                    if (dly_cnt == DLY_W'(DELAY - 1)) begin
                        state <= serial_slave_pkg::READ_FETCH;
                    end else begin
                        dly_cnt <= dly_cnt + 1'b1;
                    end
                end
                serial_slave_pkg::READ_SEND: begin
                    if (last) begin
                        last_seen <= 1'b1;
                    end
                    if (word_done) begin
                        if (!is_burst || last_seen || last) begin
                            state <= serial_slave_pkg::IDLE;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= serial_slave_pkg::BURST_GAP;
                        end
                    end
                end
                serial_slave_pkg::READ_FETCH,
                serial_slave_pkg::BURST_GAP: begin
                    fetch_phase <= !fetch_phase;
                    last_seen   <= 1'b0;
                    if (fetch_phase) begin
                        state <= serial_slave_pkg::READ_SEND;
                    end
                end
                default: state <= serial_slave_pkg::IDLE;
            endcase
        end
    end

    // the master has no way to stall on a write
    a_write_ready: assert property (
        @(posedge clk) disable iff (!rstN)
        (state == serial_slave_pkg::WRITE_WORD) |-> ready
    );

    a_one_mem_op: assert property (
        @(posedge clk) disable iff (!rstN) !(mem_we && mem_re)
    );

endmodule

//--- rtl/data_shifter.sv
//////////////////////////////////////////////////
// serial data paths, both msb first
// shift_en and send_en are never high together, so
// one bit counter serves both directions
//////////////////////////////////////////////////
`timescale 1ns/1ps

module data_shifter #(
    parameter int DATA_WIDTH = serial_slave_pkg::DEF_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  wD,
    input  logic                  shift_en,
    input  logic                  load_word,
    input  logic                  send_en,
    input  logic [DATA_WIDTH-1:0] rd_word,
    output logic [DATA_WIDTH-1:0] wr_word,
    output logic                  rD,
    output logic                  word_done
);
    localparam int CNT_W = $clog2(DATA_WIDTH + 1);

    logic [DATA_WIDTH-1:0] wr_shift;
    logic [DATA_WIDTH-1:0] rd_shift;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  step;

    assign step      = shift_en || send_en;
    // high in the cycle of the final bit, so wr_word is whole on the next cycle
    assign word_done = step && (bit_cnt == CNT_W'(DATA_WIDTH - 1));
    assign wr_word   = wr_shift;
    assign rD        = rd_shift[DATA_WIDTH-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt <= '0;
        end else if (load_word) begin
            bit_cnt <= '0;
        end else if (step) begin
            bit_cnt <= word_done ? '0 : bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (shift_en) begin
            wr_shift <= {wr_shift[DATA_WIDTH-2:0], wD};
        end
    end

    // cleared so rD idles low
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rd_shift <= '0;
        end else if (load_word) begin
            rd_shift <= rd_word;
        end else if (send_en) begin
            rd_shift <= {rd_shift[DATA_WIDTH-2:0], 1'b0};
        end
    end

    a_cnt_range: assert property (
        @(posedge clk) disable iff (!rstN) bit_cnt < CNT_W'(DATA_WIDTH)
    );

endmodule

//--- rtl/slave_memory.sv
//////////////////////////////////////////////////
// single port word memory, registered read
// contents are undefined until written
//////////////////////////////////////////////////
`timescale 1ns/1ps

module slave_memory #(
    parameter int DATA_WIDTH = serial_slave_pkg::DEF_DATA_WIDTH,
    parameter int ADDR_DEPTH = serial_slave_pkg::DEF_ADDR_DEPTH
) (
    input  logic                          clk,
    input  logic                          mem_we,
    input  logic                          mem_re,
    input  logic [$clog2(ADDR_DEPTH)-1:0] mem_addr,
    input  logic [DATA_WIDTH-1:0]         wr_word,
    output logic [DATA_WIDTH-1:0]         rd_word
);
    logic [DATA_WIDTH-1:0] mem [ADDR_DEPTH];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= wr_word;
        end
        // rd_word holds until the next read
        if (mem_re) begin
            rd_word <= mem[mem_addr];
        end
    end

    // a burst can walk past the top when the depth is not a power of two
    a_addr_range: assert property (
        @(posedge clk) (mem_we || mem_re) |-> (mem_addr < ADDR_DEPTH)
    );

endmodule

//--- rtl/serial_slave.sv
//////////////////////////////////////////////////
// serial bus slave top level
// inputs change between rising edges; ready idles high
//////////////////////////////////////////////////
`timescale 1ns/1ps

module serial_slave #(
    parameter int DATA_WIDTH = serial_slave_pkg::DEF_DATA_WIDTH,
    parameter int ADDR_DEPTH = serial_slave_pkg::DEF_ADDR_DEPTH,
    parameter int SLAVES     = serial_slave_pkg::DEF_SLAVES,
    parameter int SLAVE_ID   = serial_slave_pkg::DEF_SLAVE_ID,
    parameter int DELAY      = serial_slave_pkg::DEF_DELAY
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);
    localparam int ADDR_W = $clog2(ADDR_DEPTH);

    logic                  header_valid;
    logic                  header_match;
    logic                  is_write;
    logic                  is_burst;
    logic [ADDR_W-1:0]     start_addr;
    logic                  rx_enable;
    logic                  shift_en;
    logic                  load_word;
    logic                  send_en;
    logic                  word_done;
    logic                  mem_we;
    logic                  mem_re;
    logic [ADDR_W-1:0]     mem_addr;
    logic [DATA_WIDTH-1:0] wr_word;
    logic [DATA_WIDTH-1:0] rd_word;

    frame_receiver #(.SLAVES(SLAVES), .SLAVE_ID(SLAVE_ID), .ADDR_DEPTH(ADDR_DEPTH))
        frame_receiver_inst (.clk, .rstN, .control, .enable(rx_enable), .header_valid,
                             .header_match, .is_write, .is_burst, .start_addr);

    slave_controller #(.DELAY(DELAY), .ADDR_DEPTH(ADDR_DEPTH))
        slave_controller_inst (.clk, .rstN, .header_valid, .header_match, .is_write,
                               .is_burst, .start_addr, .valid, .last, .word_done,
                               .rx_enable, .shift_en, .load_word, .send_en, .mem_we,
                               .mem_re, .mem_addr, .ready);

    data_shifter #(.DATA_WIDTH(DATA_WIDTH))
        data_shifter_inst (.clk, .rstN, .wD, .shift_en, .load_word, .send_en, .rd_word,
                           .wr_word, .rD, .word_done);

    slave_memory #(.DATA_WIDTH(DATA_WIDTH), .ADDR_DEPTH(ADDR_DEPTH))
        slave_memory_inst (.clk, .mem_we, .mem_re, .mem_addr, .wr_word, .rd_word);

endmodule

//--- sim/tb_serial_slave.sv
//////////////////////////////////////////////////
// testbench for serial_slave, run from the project root
// stimulus and expected read data come from the stim file
// the memory is not reset, so each read follows a write
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_serial_slave;
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_DEPTH = 256;
    localparam int SLAVES     = 3;
    localparam int ID_W       = $clog2(SLAVES + 1);
    localparam int ADDR_W     = $clog2(ADDR_DEPTH);
    localparam int FRAME_LEN  = 3 + ID_W + 2 + ADDR_W;
    localparam int MAX_TESTS  = 32;
    localparam int MAX_WORDS  = 4;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;

    string                 t_name  [MAX_TESTS];
    string                 t_op    [MAX_TESTS];
    logic [2:0]            t_start [MAX_TESTS];
    int                    t_id    [MAX_TESTS];
    int                    t_count [MAX_TESTS];
    int                    t_addr  [MAX_TESTS];
    logic [DATA_WIDTH-1:0] t_data  [MAX_TESTS][MAX_WORDS];
    int                    n_tests;
    int                    errors;
    int                    watch_cycles;
    integer                seed;

    serial_slave #(.DATA_WIDTH(DATA_WIDTH), .ADDR_DEPTH(ADDR_DEPTH), .SLAVES(SLAVES),
                   .SLAVE_ID(1), .DELAY(2))
        serial_slave_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // lines starting with # are skipped, each test has four data columns
    task automatic load_tests();
        int                    fd;
        int                    got;
        int                    id;
        int                    cnt;
        int                    addr;
        string                 line;
        string                 nm;
        string                 op;
        logic [2:0]            st;
        logic [DATA_WIDTH-1:0] d [MAX_WORDS];
        n_tests = 0;
        fd = $fopen("sim/serial_slave_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                got = $fgets(line, fd);
                if (got > 1 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%s %s %b %d %d %h %h %h %h %h", nm, op, st, id, cnt,
                                  addr, d[0], d[1], d[2], d[3]);
                    if (got == 10 && cnt >= 1 && cnt <= MAX_WORDS) begin
                        t_name[n_tests]  = nm;
                        t_op[n_tests]    = op;
                        t_start[n_tests] = st;
                        t_id[n_tests]    = id;
                        t_count[n_tests] = cnt;
                        t_addr[n_tests]  = addr;
                        for (int w = 0; w < MAX_WORDS; w++) begin
                            t_data[n_tests][w] = d[w];
                        end
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_ready(input string name);
        assert (ready === 1'b1) else begin
            $display("[FAIL] %s ready expected 1 actual %b", name, ready);
            errors++;
        end
    endtask

    task automatic send_frame(input int idx);
        logic [FRAME_LEN-1:0] frame;
        logic                 wr;
        logic                 burst;
        wr    = (t_op[idx] != "rd");
        burst = (t_count[idx] > 1);
        frame = {t_start[idx], ID_W'(t_id[idx]), wr, burst, ADDR_W'(t_addr[idx])};
        for (int i = FRAME_LEN - 1; i >= 0; i--) begin
            @(negedge clk);
            control = frame[i];
        end
        // header decode cycle, data may start on the next one
        @(negedge clk);
        control = 1'b0;
    endtask

    // last rises with the first bit of the final word
    task automatic send_write(input int idx);
        int gap;
        for (int w = 0; w < t_count[idx]; w++) begin
            for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
                gap = 0;
                if (t_op[idx] == "wrgap" && ({$random(seed)} % 4) == 0) begin
                    gap = {$random(seed)} % 3 + 1;
                end
                repeat (gap) begin
                    @(negedge clk);
                    check_ready(t_name[idx]);
                    valid = 1'b0;
                end
                @(negedge clk);
                check_ready(t_name[idx]);
                valid = 1'b1;
                last  = (w == t_count[idx] - 1);
                wD    = t_data[idx][w][b];
            end
        end
        @(negedge clk);
        check_ready(t_name[idx]);
        valid = 1'b0;
        last  = 1'b0;
        wD    = 1'b0;
    endtask

    task automatic receive_read(input int idx);
        logic [DATA_WIDTH-1:0] word;
        int                    bits;
        int                    words;
        word  = '0;
        bits  = 0;
        words = 0;
        while (ready === 1'b1) @(negedge clk);
        while (words < t_count[idx]) begin
            if (ready === 1'b1) begin
                word = {word[DATA_WIDTH-2:0], rD};
                bits++;
                if (bits == DATA_WIDTH) begin
                    assert (word === t_data[idx][words]) else begin
                        $display("[FAIL] %s word %0d expected %h actual %h", t_name[idx],
                                 words, t_data[idx][words], word);
                        errors++;
                    end
                    words++;
                    bits = 0;
                end
            end else if (words == t_count[idx] - 1) begin
                // gap before the final word
                last = 1'b1;
            end
            @(negedge clk);
        end
        last = 1'b0;
    endtask

    initial begin
        int fails_before;
        int tests_failed;
        int total_bits;
        rstN    = 1'b0;
        control = 1'b0;
        wD      = 1'b0;
        valid   = 1'b0;
        last    = 1'b0;
        seed    = 32'h116c;
        errors  = 0;
        tests_failed = 0;
        total_bits   = 0;
        load_tests();
        for (int i = 0; i < n_tests; i++) begin
            total_bits += FRAME_LEN + t_count[i] * DATA_WIDTH;
        end
        watch_cycles = 4 * total_bits + 200;
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        fails_before = errors;
        assert (ready === 1'b1 && rD === 1'b0) else begin
            $display("[FAIL] reset ready,rD expected 1,0 actual %b,%b", ready, rD);
            errors++;
        end
        if (n_tests == 0) begin
            $display("no tests could be read from the stimulus file");
            errors++;
        end
        if (errors == fails_before) begin
            $display("test %-14s passed", "reset");
        end else begin
            $display("test %-14s failed", "reset");
            tests_failed++;
        end
        for (int i = 0; i < n_tests; i++) begin
            fails_before = errors;
            send_frame(i);
            if (t_op[i] == "rd") begin
                receive_read(i);
            end else begin
                send_write(i);
            end
            repeat (4) @(negedge clk);
            if (errors == fails_before) begin
                $display("test %-14s passed", t_name[i]);
            end else begin
                $display("test %-14s failed", t_name[i]);
                tests_failed++;
            end
        end
        $display("tests passed %0d, failed %0d", n_tests + 1 - tests_failed, tests_failed);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog, limit set once the stimulus is loaded
    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("run timed out after %0d cycles", watch_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- sim/serial_slave_stim.txt
# name op start id count addr(hex) data0 data1 data2 data3 (hex, expected words for rd)
# op is wr, wrgap (valid gaps) or rd; count above 1 is a burst; unused data columns are 0
single_wr     wr     111 1 1 0a deadbeef 00000000 00000000 00000000
single_rd     rd     111 1 1 0a deadbeef 00000000 00000000 00000000
burst_wr      wr     111 1 4 40 11112222 33334444 55556666 77778888
burst_rd      rd     111 1 4 40 11112222 33334444 55556666 77778888
burst_rd_mid  rd     111 1 3 41 33334444 55556666 77778888 00000000
gap_wr        wrgap  111 1 1 20 a5a50f0f 00000000 00000000 00000000
gap_rd        rd     111 1 1 20 a5a50f0f 00000000 00000000 00000000
gap_burst_wr  wrgap  111 1 2 80 0badf00d 12345678 00000000 00000000
gap_burst_rd  rd     111 1 2 80 0badf00d 12345678 00000000 00000000
other_id_wr   wr     111 2 1 0a 5a5a5a5a 00000000 00000000 00000000
other_id_rd   rd     111 1 1 0a deadbeef 00000000 00000000 00000000
bad_start_wr  wr     101 1 1 40 ffffffff 00000000 00000000 00000000
bad_start_rd  rd     111 1 1 40 11112222 00000000 00000000 00000000
top_wr        wr     111 1 1 ff 80000001 00000000 00000000 00000000
top_rd        rd     111 1 1 ff 80000001 00000000 00000000 00000000

//--- serial_slave.f
rtl/serial_slave_pkg.sv
rtl/frame_receiver.sv
rtl/slave_controller.sv
rtl/data_shifter.sv
rtl/slave_memory.sv
rtl/serial_slave.sv
sim/tb_serial_slave.sv

//--- Bender.yml
package:
  name: serial_slave

sources:
  - files:
      - rtl/serial_slave_pkg.sv
      - rtl/frame_receiver.sv
      - rtl/slave_controller.sv
      - rtl/data_shifter.sv
      - rtl/slave_memory.sv
      - rtl/serial_slave.sv
  - target: simulation
    files:
      - sim/tb_serial_slave.sv
